// File: Makefile
# Verilator build for the stream combiner

VERILATOR  = verilator
TOP        = stream_combiner_tb
FILELIST   = compile.f
OBJ_DIR    = obj_dir
FLAGS      = --timing --assert
SIM_FLAGS  = --binary -j 0 --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: compile.f
source/stream_pkg.sv
source/input_buffer.sv
source/priority_arbiter.sv
source/output_register.sv
source/stream_combiner.sv
test/stream_combiner_chk.sv
test/stream_combiner_tb.sv

// File: source/input_buffer.sv
// ----------------------------------------------------------
// Per-stream input FIFO
// ----------------------------------------------------------

module input_buffer #(
    parameter int BUFFER_DEPTH = 8
) (
    input  logic                clock,
    input  logic                rst_n,

    input  stream_pkg::in_beat_t in_beat,
    input  logic                in_valid,
    output logic                in_ready,

    output stream_pkg::in_beat_t buf_beat,
    output logic                buf_valid,
    input  logic                buf_ready
);

    localparam int ADDR_W = $clog2(BUFFER_DEPTH);

    // Pointers carry one extra wrap bit so a full queue differs from an empty one
    typedef logic [ADDR_W:0]   ptr_t;
    typedef logic [ADDR_W-1:0] addr_t;

    stream_pkg::in_beat_t mem [BUFFER_DEPTH];

    ptr_t  wr_ptr;
    ptr_t  rd_ptr;
    addr_t wr_addr;
    addr_t rd_addr;
    logic  full;
    logic  empty;
    logic  do_write;
    logic  do_read;

    assign wr_addr = wr_ptr[ADDR_W-1:0];
    assign rd_addr = rd_ptr[ADDR_W-1:0];

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) && (wr_addr == rd_addr);

    assign in_ready  = !full;
    assign buf_valid = !empty;

    assign do_write = in_valid && in_ready;
    assign do_read  = buf_valid && buf_ready;

    // Head of the queue is presented straight from storage
    assign buf_beat = mem[rd_addr];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + ptr_t'(1);
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + ptr_t'(1);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_addr] <= in_beat;
        end
    end

endmodule

// File: source/output_register.sv
// ----------------------------------------------------------
// Widening output register
// ----------------------------------------------------------

module output_register (
    input  logic                  clock,
    input  logic                  rst_n,

    input  stream_pkg::in_beat_t  sel_beat,
    input  logic                  sel_valid,
    output logic                  sel_ready,

    output stream_pkg::out_beat_t out_beat,
    output logic                  out_valid,
    input  logic                  out_ready
);

    stream_pkg::out_beat_t wide_beat;
    logic                  load;

    // Data is unsigned, so the cast pads the upper bits with zeros
    always_comb begin
        wide_beat.data = stream_pkg::data_out_t'(sel_beat.data);
        wide_beat.dest = sel_beat.dest;
        wide_beat.user = sel_beat.user;
        wide_beat.last = sel_beat.last;
    end

    // The stage can take a new beat when empty or when the held one leaves
    assign sel_ready = !out_valid || out_ready;
    assign load      = sel_valid && sel_ready;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (sel_ready) begin
            out_valid <= sel_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            out_beat <= wide_beat;
        end
    end

endmodule

// File: source/priority_arbiter.sv
// ----------------------------------------------------------
// Packet-locked priority arbiter
// ----------------------------------------------------------

module priority_arbiter #(
    parameter int N_STREAMS = 4
) (
    input  logic                 clock,
    input  logic                 rst_n,

    input  stream_pkg::in_beat_t buf_beat [N_STREAMS],
    input  logic [N_STREAMS-1:0] buf_valid,
    output logic [N_STREAMS-1:0] buf_ready,

    output stream_pkg::in_beat_t sel_beat,
    output logic                 sel_valid,
    input  logic                 sel_ready
);

    localparam int IDX_W = (N_STREAMS > 1) ? $clog2(N_STREAMS) : 1;

    typedef logic [IDX_W-1:0] idx_t;

    typedef enum logic {
        ST_IDLE,
        ST_LOCKED
    } state_t;

    state_t state;
    idx_t   lock_idx;
    idx_t   first_idx;
    idx_t   grant_idx;
    logic   any_valid;
    logic   take;

    // Scan downwards so the lowest valid index is the one left standing
    always_comb begin
        first_idx = '0;
        any_valid = 1'b0;
        for (int k = N_STREAMS - 1; k >= 0; k--) begin
            if (buf_valid[k]) begin
                first_idx = idx_t'(k);
                any_valid = 1'b1;
            end
        end
    end

    assign grant_idx = (state == ST_LOCKED) ? lock_idx : first_idx;
    assign sel_valid = (state == ST_LOCKED) ? buf_valid[grant_idx] : any_valid;
    assign sel_beat  = buf_beat[grant_idx];

    // Only the granted stream may drain
    always_comb begin
        buf_ready            = '0;
        buf_ready[grant_idx] = sel_ready;
    end

    assign take = sel_valid && sel_ready;

    // The grant moves only when a beat is actually taken
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            lock_idx <= '0;
        end else if (take) begin
            lock_idx <= grant_idx;
            if (sel_beat.last) begin
                state <= ST_IDLE;
            end else begin
                state <= ST_LOCKED;
            end
        end
    end

endmodule

// File: source/stream_combiner.sv
// ----------------------------------------------------------
// Stream combiner top level
// ----------------------------------------------------------

module stream_combiner #(
    parameter int N_STREAMS    = 4,
    parameter int BUFFER_DEPTH = 8
) (
    input  logic                  clock,
    input  logic                  rst_n,

    input  stream_pkg::in_beat_t  in_beat [N_STREAMS],
    input  logic [N_STREAMS-1:0]  in_valid,
    output logic [N_STREAMS-1:0]  in_ready,

    output stream_pkg::out_beat_t out_beat,
    output logic                  out_valid,
    input  logic                  out_ready
);

    // Buffer outputs toward the arbiter
    stream_pkg::in_beat_t buf_beat [N_STREAMS];
    logic [N_STREAMS-1:0] buf_valid;
    logic [N_STREAMS-1:0] buf_ready;

    // Selected stream toward the output stage
    stream_pkg::in_beat_t sel_beat;
    logic                 sel_valid;
    logic                 sel_ready;

    for (genvar i = 0; i < N_STREAMS; i++) begin : g_buffer
        input_buffer #(
            .BUFFER_DEPTH(BUFFER_DEPTH)
        ) buffer0 (
            .clock    (clock),
            .rst_n    (rst_n),
            .in_beat  (in_beat[i]),
            .in_valid (in_valid[i]),
            .in_ready (in_ready[i]),
            .buf_beat (buf_beat[i]),
            .buf_valid(buf_valid[i]),
            .buf_ready(buf_ready[i])
        );
    end

    priority_arbiter #(
        .N_STREAMS(N_STREAMS)
    ) arbiter0 (
        .clock    (clock),
        .rst_n    (rst_n),
        .buf_beat (buf_beat),
        .buf_valid(buf_valid),
        .buf_ready(buf_ready),
        .sel_beat (sel_beat),
        .sel_valid(sel_valid),
        .sel_ready(sel_ready)
    );

    output_register output0 (
        .clock    (clock),
        .rst_n    (rst_n),
        .sel_beat (sel_beat),
        .sel_valid(sel_valid),
        .sel_ready(sel_ready),
        .out_beat (out_beat),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

endmodule

// File: source/stream_pkg.sv
// ----------------------------------------------------------
// Stream combiner shared types
// ----------------------------------------------------------

package stream_pkg;

    // Payload widths of the narrow input side and the wide output side
    typedef logic [15:0] data_in_t;
    typedef logic [31:0] data_out_t;

    // Sideband fields shared by both sides
    typedef logic [7:0] dest_t;
    typedef logic [7:0] user_t;

    // One beat of a narrow input stream takes 33 bits
    typedef struct packed {
        data_in_t data;
        dest_t    dest;
        user_t    user;
        logic     last;
    } in_beat_t;

    // One beat of the combined output stream takes 49 bits
    typedef struct packed {
        data_out_t data;
        dest_t     dest;
        user_t     user;
        logic      last;
    } out_beat_t;

endpackage

// File: test/stream_combiner_chk.sv
// ----------------------------------------------------------
// Stream combiner output checks
// ----------------------------------------------------------

module stream_combiner_chk (
    input logic                  clock,
    input logic                  rst_n,
    input stream_pkg::out_beat_t out_beat,
    input logic                  out_valid,
    input logic                  out_ready
);

    logic              in_packet;
    stream_pkg::user_t packet_user;

    // Follow packet boundaries on the output handshake
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            in_packet   <= 1'b0;
            packet_user <= '0;
        end else if (out_valid && out_ready) begin
            in_packet   <= !out_beat.last;
            packet_user <= out_beat.user;
        end
    end

    // A stalled beat must wait unchanged
    hold_while_stalled: assert property (
        @(posedge clock) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_beat)
    ) else $error("out_beat or out_valid changed while the output was stalled");

    quiet_in_reset: assert property (@(posedge clock) !rst_n |-> !out_valid)
        else $error("out_valid was high during reset");

    no_interleave: assert property (
        @(posedge clock) disable iff (!rst_n)
        out_valid && out_ready && in_packet |-> out_beat.user == packet_user
    ) else $error("output switched streams inside a packet");

endmodule

bind stream_combiner stream_combiner_chk chk0 (
    .clock    (clock),
    .rst_n    (rst_n),
    .out_beat (out_beat),
    .out_valid(out_valid),
    .out_ready(out_ready)
);

// File: test/stream_combiner_tb.sv
// ----------------------------------------------------------
// Stream combiner testbench
// ----------------------------------------------------------

module stream_combiner_tb;

    localparam int N_STREAMS    = 4;
    localparam int BUFFER_DEPTH = 8;
    localparam int CLOCK_PERIOD = 40;
    localparam int DRIVE_DELAY  = 5;
    localparam int RESET_CYCLES = 3;
    localparam int FULL_STREAM  = 3;

    // Watchdog budget taken from the longest possible run
    localparam int RANDOM_PACKETS  = 20;
    localparam int MAX_PACKET_LEN  = 6;
    localparam int DIRECTED_BEATS  = 42;
    localparam int MAX_BEATS       = DIRECTED_BEATS
                                   + N_STREAMS * RANDOM_PACKETS * MAX_PACKET_LEN;
    localparam int DRAIN_CYCLES    = 8;
    localparam int WATCHDOG_CYCLES = MAX_BEATS * DRAIN_CYCLES + 200;

    typedef enum logic [1:0] {
        READY_LOW,
        READY_HIGH,
        READY_RANDOM
    } ready_mode_t;

    logic                  clock;
    logic                  rst_n;
    stream_pkg::in_beat_t  in_beat [N_STREAMS];
    logic [N_STREAMS-1:0]  in_valid;
    logic [N_STREAMS-1:0]  in_ready;
    stream_pkg::out_beat_t out_beat;
    logic                  out_valid;
    logic                  out_ready;

    // Beats waiting to be offered, and beats accepted but not yet seen at the output
    stream_pkg::in_beat_t  to_send [N_STREAMS][$];
    stream_pkg::in_beat_t  sent_q  [N_STREAMS][$];
    stream_pkg::out_beat_t drain_seq[$];
    int                    accepted_cnt [N_STREAMS];
    ready_mode_t           ready_mode;
    int                    gap_pct;
    logic                  record_order;

    stream_combiner #(
        .N_STREAMS   (N_STREAMS),
        .BUFFER_DEPTH(BUFFER_DEPTH)
    ) dut0 (
        .clock    (clock),
        .rst_n    (rst_n),
        .in_beat  (in_beat),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .out_beat (out_beat),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

    initial begin : clock_gen
        clock = 1'b0;
        forever begin
            #(CLOCK_PERIOD / 2) clock = ~clock;
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("Mismatch at time %0t: %s is %h, expected %h", $time, name, got, want);
            fail_run("output value differs from the reference");
        end
    endtask

    // Output beat is the input beat with data zero-extended to 32 bits
    function automatic stream_pkg::out_beat_t expected_beat(input stream_pkg::in_beat_t b);
        stream_pkg::out_beat_t o;
        o.data = {16'h0000, b.data};
        o.dest = b.dest;
        o.user = b.user;
        o.last = b.last;
        return o;
    endfunction

    function automatic int unsent_beats();
        int total;
        total = 0;
        for (int k = 0; k < N_STREAMS; k++) begin
            total += to_send[k].size();
        end
        return total;
    endfunction

    function automatic int pending_beats();
        int total;
        total = unsent_beats();
        for (int k = 0; k < N_STREAMS; k++) begin
            total += sent_q[k].size();
        end
        return total;
    endfunction

    task automatic queue_packet(input int stream, input int length);
        stream_pkg::in_beat_t beat;
        for (int i = 0; i < length; i++) begin
            beat.data = stream_pkg::data_in_t'($urandom);
            beat.dest = stream_pkg::dest_t'($urandom);
            beat.user = stream_pkg::user_t'(stream);
            beat.last = (i == length - 1);
            to_send[stream].push_back(beat);
        end
    endtask

    task automatic wait_accepted();
        while (unsent_beats() != 0) begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic wait_drained();
        while (pending_beats() != 0) begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic check_drain_order();
        int idx;
        int prev;
        idx = 0;
        prev = 0;
        check_value("drained beat count", 32'(drain_seq.size()), 32'(N_STREAMS * 5));
        // The packet in flight when the stall began finishes first
        while (idx < drain_seq.size() && !drain_seq[idx].last) begin
            idx++;
        end
        idx++;
        while (idx < drain_seq.size()) begin
            if (int'(drain_seq[idx].user) < prev) begin
                fail_run($sformatf("stream %0d drained after stream %0d",
                                   drain_seq[idx].user, prev));
            end
            prev = int'(drain_seq[idx].user);
            idx++;
        end
    endtask

    // Offers queued beats per stream, and logs each accepted beat
    initial begin : drive_inputs
        logic [N_STREAMS-1:0] took;
        forever begin
            @(posedge clock);
            took = in_valid & in_ready;
            for (int k = 0; k < N_STREAMS; k++) begin
                if (rst_n && took[k]) begin
                    sent_q[k].push_back(to_send[k].pop_front());
                    accepted_cnt[k]++;
                end
            end
            #DRIVE_DELAY;
            for (int k = 0; k < N_STREAMS; k++) begin
                if (!in_valid[k] || took[k]) begin
                    if (to_send[k].size() > 0 && $urandom_range(99) >= gap_pct) begin
                        in_beat[k]  = to_send[k][0];
                        in_valid[k] = 1'b1;
                    end else begin
                        in_valid[k] = 1'b0;
                    end
                end
            end
        end
    end

    initial begin : drive_out_ready
        forever begin
            @(posedge clock);
            #DRIVE_DELAY;
            case (ready_mode)
                READY_HIGH:   out_ready = 1'b1;
                READY_RANDOM: out_ready = 1'($urandom_range(1));
                default:      out_ready = 1'b0;
            endcase
        end
    end

    initial begin : compare_output
        stream_pkg::out_beat_t want;
        int                    src;
        logic                  mid_packet;
        stream_pkg::user_t     packet_user;
        mid_packet  = 1'b0;
        packet_user = '0;
        forever begin
            @(posedge clock);
            if (rst_n && out_valid && out_ready) begin
                src = int'(out_beat.user);
                if (src >= N_STREAMS || sent_q[src].size() == 0) begin
                    fail_run($sformatf("output beat from stream %0d was never sent", src));
                end else if (mid_packet && out_beat.user != packet_user) begin
                    fail_run("packets from two streams interleaved at the output");
                end else begin
                    want = expected_beat(sent_q[src].pop_front());
                    check_value("out_beat.data", out_beat.data, want.data);
                    check_value("out_beat.dest", 32'(out_beat.dest), 32'(want.dest));
                    check_value("out_beat.user", 32'(out_beat.user), 32'(want.user));
                    check_value("out_beat.last", 32'(out_beat.last), 32'(want.last));
                    if (record_order) begin
                        drain_seq.push_back(out_beat);
                    end
                    mid_packet  = !out_beat.last;
                    packet_user = out_beat.user;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        fail_run("watchdog expired before the tests finished");
    end

    initial begin : main
        int guard;
        void'($urandom(32'h327e5500));
        rst_n        = 1'b0;
        in_valid     = '0;
        out_ready    = 1'b0;
        ready_mode   = READY_LOW;
        gap_pct      = 0;
        record_order = 1'b0;
        for (int k = 0; k < N_STREAMS; k++) begin
            in_beat[k]      = '0;
            accepted_cnt[k] = 0;
        end
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY rst_n = 1'b1;

        // Idle state right after reset
        @(posedge clock);
        #1;
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("in_ready", 32'(in_ready), 32'((1 << N_STREAMS) - 1));

        // Single stream with a free output
        ready_mode = READY_HIGH;
        queue_packet(2, 4);
        queue_packet(2, 1);
        queue_packet(2, 5);
        wait_drained();

        // Load every stream during a stall, then drain in priority order
        ready_mode   = READY_LOW;
        record_order = 1'b1;
        for (int k = 0; k < N_STREAMS; k++) begin
            queue_packet(k, 2);
            queue_packet(k, 3);
        end
        wait_accepted();
        repeat (2) @(posedge clock);
        ready_mode = READY_HIGH;
        wait_drained();
        record_order = 1'b0;
        check_drain_order();

        // One stream under back-pressure fills its buffer and the output stage
        ready_mode                = READY_LOW;
        accepted_cnt[FULL_STREAM] = 0;
        queue_packet(FULL_STREAM, 12);
        guard = 0;
        while (in_ready[FULL_STREAM]) begin
            @(posedge clock);
            #1;
            guard++;
            if (guard > 4 * BUFFER_DEPTH) begin
                fail_run("in_ready of stream 3 never fell under back-pressure");
            end
        end
        if (accepted_cnt[FULL_STREAM] < BUFFER_DEPTH ||
            accepted_cnt[FULL_STREAM] > BUFFER_DEPTH + 1) begin
            fail_run($sformatf("stream 3 accepted %0d beats before in_ready fell",
                               accepted_cnt[FULL_STREAM]));
        end
        ready_mode = READY_HIGH;
        wait_drained();

        // Random traffic with gaps on the inputs and a random output ready
        gap_pct    = 25;
        ready_mode = READY_RANDOM;
        for (int p = 0; p < RANDOM_PACKETS; p++) begin
            for (int k = 0; k < N_STREAMS; k++) begin
                queue_packet(k, 1 + int'($urandom_range(MAX_PACKET_LEN - 1)));
            end
        end
        wait_drained();
        repeat (4) @(posedge clock);

        if (out_valid) begin
            fail_run("an extra beat was left at the output after all beats arrived");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule
